//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

//--- rtl/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        cp0_wen,
    input  creg_addr_t  cp0_waddr,
    input  word_t       cp0_wdata,
    input  logic        exc_take,
    input  exc_code_t   exc_code,
    input  word_t       exc_epc,
    input  logic        exc_bd,
    input  word_t       exc_badvaddr,
    input  logic        eret,
    input  creg_addr_t  raddr,
    output cp0_status_t status,
    output cp0_cause_t  cause,
    output word_t       rdata
);

    cp0_word_u wr;
    word_t     epc;
    word_t     badvaddr;

    assign wr.w = cp0_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            status     <= '0;
            status.exl <= 1'b1;
            cause      <= '0;
            epc        <= '0;
            badvaddr   <= '0;
        end else if (exc_take) begin
            status.exl     <= 1'b1;
            cause.exc_code <= exc_code;
            cause.bd       <= exc_bd;
            epc            <= exc_epc;
            // bad address only for address errors
            if (exc_code == ADEL || exc_code == ADES) begin
                badvaddr <= exc_badvaddr;
            end
        end else if (eret) begin
            status.exl <= 1'b0;
        end else if (cp0_wen) begin
            case (cp0_waddr)
                CP0_STATUS: begin
                    status.im  <= wr.status.im;
                    status.exl <= wr.status.exl;
                    status.ie  <= wr.status.ie;
                end
                CP0_CAUSE: begin
                    cause.ip[1:0] <= wr.cause.ip[1:0];
                end
                CP0_EPC: begin
                    epc <= cp0_wdata;
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (raddr)
            CP0_STATUS:   rdata = status;
            CP0_CAUSE:    rdata = cause;
            CP0_EPC:      rdata = epc;
            CP0_BADVADDR: rdata = badvaddr;
            default:      rdata = '0;
        endcase
    end

    a_exc_eret_excl: assert property (@(posedge clk) disable iff (reset)
        !(exc_take && eret));

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram import mips_pkg::*; #(
    parameter int RAM_AWIDTH = 10
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [3:0] wb_sel,
    input  word_t      wb_adr,
    input  word_t      wb_dat_w,
    output word_t      wb_dat_r,
    output logic       wb_ack
);

    word_t                 mem [2**RAM_AWIDTH];
    logic [RAM_AWIDTH-1:0] widx;
    logic                  req;

    assign widx = wb_adr[RAM_AWIDTH+1:2];
    // first cycle of a strobe, the ack cycle itself is not a new request
    assign req  = wb_cyc && wb_stb && !wb_ack;

    initial begin
        for (int i = 0; i < 2**RAM_AWIDTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            if (wb_we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wb_sel[b]) begin
                        mem[widx][8*b +: 8] <= wb_dat_w[8*b +: 8];
                    end
                end
            end
            wb_dat_r <= mem[widx];
        end
    end

endmodule

//--- rtl/mem_load_extract.sv
`timescale 1ns/1ps

module mem_load_extract import mips_pkg::*; (
    input  logic [1:0]  addr_lo,
    input  decoded_op_t op,
    input  word_t       rd_raw,
    output word_t       rd
);

    logic [7:0]  byte_v;
    logic [15:0] half_v;

    // little-endian lane pick
    assign byte_v = rd_raw[{addr_lo, 3'b000} +: 8];
    assign half_v = addr_lo[1] ? rd_raw[31:16] : rd_raw[15:0];

    always_comb begin
        case (op)
            LB: begin
                rd = {{24{byte_v[7]}}, byte_v};
            end
            LBU: begin
                rd = {24'h000000, byte_v};
            end
            LH: begin
                rd = {{16{half_v[15]}}, half_v};
            end
            LHU: begin
                rd = {16'h0000, half_v};
            end
            default: begin
                // LW and anything else passes the bus word
                rd = rd_raw;
            end
        endcase
    end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage import mips_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  decoded_op_t in_op,
    input  word_t       in_aluout,
    input  word_t       in_writedata,
    input  creg_addr_t  in_writereg,
    input  word_t       in_pc,
    input  logic        in_delay_slot,
    input  logic        in_exc_ri,
    input  logic        in_exc_of,
    input  logic [5:0]  ext_int,
    output logic        out_valid,
    output decoded_op_t out_op,
    output word_t       out_result,
    output creg_addr_t  out_writereg,
    output logic        out_exc_valid,
    output exc_code_t   out_exc_code,
    output logic        wb_cyc,
    output logic        wb_stb,
    output logic        wb_we,
    output logic [3:0]  wb_sel,
    output word_t       wb_adr,
    output word_t       wb_dat_w,
    input  word_t       wb_dat_r,
    input  logic        wb_ack,
    input  cp0_status_t status,
    input  cp0_cause_t  cause,
    input  word_t       cp0_rdata,
    output creg_addr_t  cp0_raddr,
    output logic        cp0_wen,
    output creg_addr_t  cp0_waddr,
    output word_t       cp0_wdata,
    output logic        exc_take,
    output exc_code_t   exc_code,
    output word_t       exc_epc,
    output logic        exc_bd,
    output word_t       exc_badvaddr,
    output logic        eret
);

    logic        r_valid;
    decoded_op_t r_op;
    word_t       r_aluout;
    word_t       r_wdata;
    creg_addr_t  r_writereg;
    word_t       r_pc;
    logic        r_delay_slot;
    logic        r_exc_ri;
    logic        r_exc_of;
    logic        r_int;

    cp0_word_u   byp_word;
    cp0_status_t eff_status;
    cp0_cause_t  eff_cause;
    logic [7:0]  int_vec;
    logic        int_now;

    logic        is_load;
    logic        is_store;
    logic        misalign;
    logic        exc_any;
    exc_code_t   exc_sel;
    logic        bus_req;
    logic        done;
    logic [3:0]  st_sel;
    word_t       st_wd;
    word_t       ld_data;

    // interrupt is sampled at acceptance, so the CP0 update retiring
    // in this same cycle has to be seen here
    assign byp_word.w = cp0_wdata;

    always_comb begin
        eff_status = status;
        eff_cause  = cause;
        if (cp0_wen && cp0_waddr == CP0_STATUS) begin
            eff_status.im  = byp_word.status.im;
            eff_status.exl = byp_word.status.exl;
            eff_status.ie  = byp_word.status.ie;
        end
        if (cp0_wen && cp0_waddr == CP0_CAUSE) begin
            eff_cause.ip[1:0] = byp_word.cause.ip[1:0];
        end
        if (exc_take) begin
            eff_status.exl = 1'b1;
        end else if (eret) begin
            eff_status.exl = 1'b0;
        end
    end

    assign int_vec = ({ext_int, 2'b00} | eff_cause.ip) & eff_status.im;
    assign int_now = (int_vec != 8'h00) && eff_status.ie && !eff_status.exl;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_valid <= 1'b0;
        end else if (in_ready) begin
            r_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            r_op         <= in_op;
            r_aluout     <= in_aluout;
            r_wdata      <= in_writedata;
            r_writereg   <= in_writereg;
            r_pc         <= in_pc;
            r_delay_slot <= in_delay_slot;
            r_exc_ri     <= in_exc_ri;
            r_exc_of     <= in_exc_of;
            r_int        <= int_now;
        end
    end

    assign is_load  = r_op inside {LB, LBU, LH, LHU, LW};
    assign is_store = r_op inside {SB, SH, SW};
    assign misalign = ((r_op inside {LW, SW}) && r_aluout[1:0] != 2'b00) ||
                      ((r_op inside {LH, LHU, SH}) && r_aluout[0]);

    // interrupt, RI, OV, SYS, BP, then address errors
    always_comb begin
        exc_any = 1'b1;
        exc_sel = INT;
        if (r_int) begin
            exc_sel = INT;
        end else if (r_exc_ri) begin
            exc_sel = RI;
        end else if (r_exc_of) begin
            exc_sel = OV;
        end else if (r_op == SYSCALL) begin
            exc_sel = SYS;
        end else if (r_op == BREAK) begin
            exc_sel = BP;
        end else if (misalign && is_load) begin
            exc_sel = ADEL;
        end else if (misalign && is_store) begin
            exc_sel = ADES;
        end else begin
            exc_any = 1'b0;
        end
    end

    // only aligned, non-excepting accesses reach the bus
    assign bus_req  = r_valid && (is_load || is_store) && !exc_any;
    assign done     = r_valid && (!bus_req || wb_ack);
    assign in_ready = !r_valid || done;

    mem_store_align u_store_align (
        .addr_lo (r_aluout[1:0]),
        .op      (r_op),
        .wd_raw  (r_wdata),
        .sel     (st_sel),
        .wd      (st_wd)
    );

    mem_load_extract u_load_extract (
        .addr_lo (r_aluout[1:0]),
        .op      (r_op),
        .rd_raw  (wb_dat_r),
        .rd      (ld_data)
    );

    assign wb_cyc   = bus_req;
    assign wb_stb   = bus_req;
    assign wb_we    = is_store;
    assign wb_sel   = is_load ? 4'b1111 : st_sel;
    assign wb_adr   = {r_aluout[31:2], 2'b00};
    assign wb_dat_w = st_wd;

    // MFC0 and MTC0 carry the CP0 register number in aluout[4:0]
    assign cp0_raddr = r_aluout[4:0];
    assign cp0_waddr = r_aluout[4:0];
    assign cp0_wdata = r_wdata;
    assign cp0_wen   = done && r_op == MTC0 && !exc_any;
    assign eret      = done && r_op == ERET && !exc_any;

    assign exc_take     = done && exc_any;
    assign exc_code     = exc_sel;
    assign exc_epc      = r_delay_slot ? r_pc - 32'd4 : r_pc;
    assign exc_bd       = r_delay_slot;
    assign exc_badvaddr = r_aluout;

    assign out_valid     = done;
    assign out_op        = r_op;
    assign out_writereg  = r_writereg;
    assign out_exc_valid = exc_take;
    assign out_exc_code  = exc_sel;

    always_comb begin
        if (is_load) begin
            out_result = ld_data;
        end else if (r_op == MFC0) begin
            out_result = cp0_rdata;
        end else begin
            out_result = r_aluout;
        end
    end

    // the slave only acks an open strobe
    a_ack_in_stb: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> wb_cyc && wb_stb);

    a_adr_hold: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> $stable(wb_adr));

    // fixed one-cycle RAM latency
    a_ack_next: assert property (@(posedge clk) disable iff (reset)
        wb_stb && !wb_ack |=> wb_ack);

endmodule

//--- rtl/mem_store_align.sv
`timescale 1ns/1ps

module mem_store_align import mips_pkg::*; (
    input  logic [1:0]  addr_lo,
    input  decoded_op_t op,
    input  word_t       wd_raw,
    output logic [3:0]  sel,
    output word_t       wd
);

    always_comb begin
        sel = 4'b0000;
        wd  = wd_raw;
        case (op)
            SB: begin
                // byte copied to every lane, one lane enabled
                wd  = {4{wd_raw[7:0]}};
                sel = 4'b0001 << addr_lo;
            end
            SH: begin
                wd  = {2{wd_raw[15:0]}};
                sel = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            SW: begin
                sel = 4'b1111;
            end
            default: begin
                // loads and non-memory ops write nothing
                sel = 4'b0000;
            end
        endcase
    end

endmodule

//--- rtl/mem_subsystem.sv
`timescale 1ns/1ps

module mem_subsystem import mips_pkg::*; #(
    parameter int RAM_AWIDTH = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    output logic        in_ready,
    input  decoded_op_t in_op,
    input  word_t       in_aluout,
    input  word_t       in_writedata,
    input  creg_addr_t  in_writereg,
    input  word_t       in_pc,
    input  logic        in_delay_slot,
    input  logic        in_exc_ri,
    input  logic        in_exc_of,
    input  logic [5:0]  ext_int,
    output logic        out_valid,
    output decoded_op_t out_op,
    output word_t       out_result,
    output creg_addr_t  out_writereg,
    output logic        out_exc_valid,
    output exc_code_t   out_exc_code
);

    // wishbone
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [3:0]  wb_sel;
    word_t       wb_adr;
    word_t       wb_dat_w;
    word_t       wb_dat_r;
    logic        wb_ack;

    // cp0 side
    cp0_status_t status;
    cp0_cause_t  cause;
    word_t       cp0_rdata;
    creg_addr_t  cp0_raddr;
    logic        cp0_wen;
    creg_addr_t  cp0_waddr;
    word_t       cp0_wdata;
    logic        exc_take;
    exc_code_t   exc_code;
    word_t       exc_epc;
    logic        exc_bd;
    word_t       exc_badvaddr;
    logic        eret;

    mem_stage u_mem_stage (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_aluout     (in_aluout),
        .in_writedata  (in_writedata),
        .in_writereg   (in_writereg),
        .in_pc         (in_pc),
        .in_delay_slot (in_delay_slot),
        .in_exc_ri     (in_exc_ri),
        .in_exc_of     (in_exc_of),
        .ext_int       (ext_int),
        .out_valid     (out_valid),
        .out_op        (out_op),
        .out_result    (out_result),
        .out_writereg  (out_writereg),
        .out_exc_valid (out_exc_valid),
        .out_exc_code  (out_exc_code),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_sel        (wb_sel),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .status        (status),
        .cause         (cause),
        .cp0_rdata     (cp0_rdata),
        .cp0_raddr     (cp0_raddr),
        .cp0_wen       (cp0_wen),
        .cp0_waddr     (cp0_waddr),
        .cp0_wdata     (cp0_wdata),
        .exc_take      (exc_take),
        .exc_code      (exc_code),
        .exc_epc       (exc_epc),
        .exc_bd        (exc_bd),
        .exc_badvaddr  (exc_badvaddr),
        .eret          (eret)
    );

    cp0_regs u_cp0_regs (
        .clk          (clk),
        .reset        (reset),
        .cp0_wen      (cp0_wen),
        .cp0_waddr    (cp0_waddr),
        .cp0_wdata    (cp0_wdata),
        .exc_take     (exc_take),
        .exc_code     (exc_code),
        .exc_epc      (exc_epc),
        .exc_bd       (exc_bd),
        .exc_badvaddr (exc_badvaddr),
        .eret         (eret),
        .raddr        (cp0_raddr),
        .status       (status),
        .cause        (cause),
        .rdata        (cp0_rdata)
    );

    data_ram #(
        .RAM_AWIDTH (RAM_AWIDTH)
    ) u_data_ram (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

endmodule

//--- rtl/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    // decoded op as it leaves execute, ALU covers everything else
    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW,
        MFC0,
        MTC0,
        SYSCALL,
        BREAK,
        ERET,
        ALU
    } decoded_op_t;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    // Status, only IM, EXL and IE are implemented
    typedef struct packed {
        logic [15:0] zero_hi;
        logic [7:0]  im;
        logic [5:0]  zero_lo;
        logic        exl;
        logic        ie;
    } cp0_status_t;

    // Cause, software may write ip[1:0] only
    typedef struct packed {
        logic        bd;
        logic [14:0] zero_hi;
        logic [7:0]  ip;
        logic        zero_mid;
        exc_code_t   exc_code;
        logic [1:0]  zero_lo;
    } cp0_cause_t;

    // one MTC0 write word, viewed by target register
    typedef union packed {
        word_t       w;
        cp0_status_t status;
        cp0_cause_t  cause;
    } cp0_word_u;

    localparam creg_addr_t CP0_BADVADDR = 5'd8;
    localparam creg_addr_t CP0_STATUS   = 5'd12;
    localparam creg_addr_t CP0_CAUSE    = 5'd13;
    localparam creg_addr_t CP0_EPC      = 5'd14;

endpackage

//--- sources.f
rtl/mips_pkg.sv
rtl/mem_store_align.sv
rtl/mem_load_extract.sv
rtl/mem_stage.sv
rtl/cp0_regs.sv
rtl/data_ram.sv
rtl/mem_subsystem.sv
verif/mem_checker.sv
verif/tb_mem_subsystem.sv

//--- verif/mem_checker.sv
`timescale 1ns/1ps

module mem_checker import mips_pkg::*; #(
    parameter int RAM_AWIDTH = 10
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic        in_ready,
    input  decoded_op_t in_op,
    input  word_t       in_aluout,
    input  word_t       in_writedata,
    input  creg_addr_t  in_writereg,
    input  word_t       in_pc,
    input  logic        in_delay_slot,
    input  logic        in_exc_ri,
    input  logic        in_exc_of,
    input  logic [5:0]  ext_int,
    input  logic        out_valid,
    input  decoded_op_t out_op,
    input  word_t       out_result,
    input  creg_addr_t  out_writereg,
    input  logic        out_exc_valid,
    input  exc_code_t   out_exc_code,
    output int          value_errs,
    output int          order_errs,
    output int          accepted,
    output int          retired
);

    typedef struct packed {
        decoded_op_t op;
        creg_addr_t  writereg;
        logic        exc;
        exc_code_t   code;
        word_t       result;
        int          due;
    } exp_t;

    exp_t  exp_q[$];
    word_t ram [2**RAM_AWIDTH];

    // edge count since reset, and whether the oldest item is due now
    int    cyc;
    logic  due_now;

    // cp0 model, implemented fields only
    logic [7:0] m_im;
    logic       m_exl;
    logic       m_ie;
    logic [1:0] m_ip;
    logic       m_bd;
    exc_code_t  m_code;
    word_t      m_epc;
    word_t      m_badvaddr;

    initial begin
        for (int i = 0; i < 2**RAM_AWIDTH; i++) begin
            ram[i] = '0;
        end
    end

    function automatic word_t load_value(decoded_op_t op, word_t w, logic [1:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * a));
        h = 16'(w >> (16 * a[1]));
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // byte-lane merge of a store into the old word
    function automatic word_t store_merge(decoded_op_t op, word_t old, word_t wd,
                                          logic [1:0] a);
        word_t mask;
        word_t data;
        case (op)
            SB: begin
                mask = 32'h0000_00ff << (8 * a);
                data = {24'h0, wd[7:0]} << (8 * a);
            end
            SH: begin
                mask = 32'h0000_ffff << (16 * a[1]);
                data = {16'h0, wd[15:0]} << (16 * a[1]);
            end
            default: begin
                mask = 32'hffff_ffff;
                data = wd;
            end
        endcase
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic word_t cp0_read(creg_addr_t a);
        case (a)
            CP0_STATUS:   return {16'h0, m_im, 6'h0, m_exl, m_ie};
            CP0_CAUSE:    return {m_bd, 15'h0, 6'h0, m_ip, 1'b0, m_code, 2'b00};
            CP0_EPC:      return m_epc;
            CP0_BADVADDR: return m_badvaddr;
            default:      return '0;
        endcase
    endfunction

    task automatic report_mismatch(string field, word_t got, word_t exp);
        $display("Fail %0t: %s mismatch, got %h expected %h", $time, field, got, exp);
        value_errs++;
    endtask

    task automatic accept_item();
        exp_t                  e;
        logic [7:0]            pend;
        logic                  take_int;
        logic                  is_ld;
        logic                  is_st;
        logic                  mis;
        logic [RAM_AWIDTH-1:0] idx;
        pend     = ({ext_int, 2'b00} | {6'h0, m_ip}) & m_im;
        take_int = (pend != 8'h00) && m_ie && !m_exl;
        is_ld    = in_op inside {LB, LBU, LH, LHU, LW};
        is_st    = in_op inside {SB, SH, SW};
        mis      = ((in_op inside {LW, SW}) && in_aluout[1:0] != 2'b00) ||
                   ((in_op inside {LH, LHU, SH}) && in_aluout[0]);
        idx      = in_aluout[RAM_AWIDTH+1:2];
        e.op       = in_op;
        e.writereg = in_writereg;
        e.exc      = 1'b1;
        e.code     = INT;
        e.result   = in_aluout;
        if (take_int) e.code = INT;
        else if (in_exc_ri) e.code = RI;
        else if (in_exc_of) e.code = OV;
        else if (in_op == SYSCALL) e.code = SYS;
        else if (in_op == BREAK) e.code = BP;
        else if (mis && is_ld) e.code = ADEL;
        else if (mis && is_st) e.code = ADES;
        else e.exc = 1'b0;
        // a bus access retires two cycles after acceptance, the rest one
        e.due = cyc + (((is_ld || is_st) && !e.exc) ? 2 : 1);
        if (e.exc) begin
            m_exl  = 1'b1;
            m_code = e.code;
            m_bd   = in_delay_slot;
            m_epc  = in_delay_slot ? in_pc - 32'd4 : in_pc;
            if (e.code == ADEL || e.code == ADES) begin
                m_badvaddr = in_aluout;
            end
        end else if (is_ld) begin
            e.result = load_value(in_op, ram[idx], in_aluout[1:0]);
        end else if (is_st) begin
            ram[idx] = store_merge(in_op, ram[idx], in_writedata, in_aluout[1:0]);
        end else if (in_op == MFC0) begin
            e.result = cp0_read(in_aluout[4:0]);
        end else if (in_op == MTC0) begin
            case (in_aluout[4:0])
                CP0_STATUS: begin
                    m_im  = in_writedata[15:8];
                    m_exl = in_writedata[1];
                    m_ie  = in_writedata[0];
                end
                CP0_CAUSE: m_ip = in_writedata[9:8];
                CP0_EPC:   m_epc = in_writedata;
                default: begin
                end
            endcase
        end else if (in_op == ERET) begin
            m_exl = 1'b0;
        end
        exp_q.push_back(e);
        accepted++;
    endtask

    task automatic check_retire();
        exp_t e;
        if (exp_q.size() == 0) begin
            $display("%0t: out_valid pulsed with no accepted item outstanding", $time);
            order_errs++;
        end else begin
            e = exp_q.pop_front();
            if (out_op !== e.op) report_mismatch("op", 32'(out_op), 32'(e.op));
            if (out_writereg !== e.writereg) begin
                report_mismatch("writereg", 32'(out_writereg), 32'(e.writereg));
            end
            if (out_exc_valid !== e.exc) begin
                report_mismatch("exc_valid", 32'(out_exc_valid), 32'(e.exc));
            end else if (e.exc && out_exc_code !== e.code) begin
                report_mismatch("exc_code", 32'(out_exc_code), 32'(e.code));
            end
            // result is only meaningful without an exception
            if (!e.exc && out_result !== e.result) begin
                report_mismatch("result", out_result, e.result);
            end
        end
        retired++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            m_im       = '0;
            m_exl      = 1'b1;
            m_ie       = 1'b0;
            m_ip       = '0;
            m_bd       = 1'b0;
            m_code     = INT;
            m_epc      = '0;
            m_badvaddr = '0;
            value_errs = 0;
            order_errs = 0;
            accepted   = 0;
            retired    = 0;
            cyc        = 0;
        end else begin
            due_now = (exp_q.size() != 0) && (exp_q[0].due == cyc);
            if (out_valid !== due_now) begin
                report_mismatch("out_valid", 32'(out_valid), 32'(due_now));
            end
            // stage is free when empty or when its item retires now
            if (in_ready !== (exp_q.size() == 0 || due_now)) begin
                report_mismatch("in_ready", 32'(in_ready), 32'(exp_q.size() == 0 || due_now));
            end
            // retire first, an acceptance in the same cycle is a newer item
            if (out_valid) check_retire();
            if (in_valid && in_ready) accept_item();
            cyc++;
        end
    end

endmodule

//--- verif/tb_mem_subsystem.sv
`timescale 1ns/1ps

module tb_mem_subsystem import mips_pkg::*; ();

    localparam int N_ITEMS        = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ITEMS * 3 + 200;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    decoded_op_t in_op;
    word_t       in_aluout;
    word_t       in_writedata;
    creg_addr_t  in_writereg;
    word_t       in_pc;
    logic        in_delay_slot;
    logic        in_exc_ri;
    logic        in_exc_of;
    logic [5:0]  ext_int;
    logic        out_valid;
    decoded_op_t out_op;
    word_t       out_result;
    creg_addr_t  out_writereg;
    logic        out_exc_valid;
    exc_code_t   out_exc_code;

    int value_errs;
    int order_errs;
    int accepted;
    int retired;
    int cycles = 0;

    mem_subsystem #(
        .RAM_AWIDTH (10)
    ) UUT (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_aluout     (in_aluout),
        .in_writedata  (in_writedata),
        .in_writereg   (in_writereg),
        .in_pc         (in_pc),
        .in_delay_slot (in_delay_slot),
        .in_exc_ri     (in_exc_ri),
        .in_exc_of     (in_exc_of),
        .ext_int       (ext_int),
        .out_valid     (out_valid),
        .out_op        (out_op),
        .out_result    (out_result),
        .out_writereg  (out_writereg),
        .out_exc_valid (out_exc_valid),
        .out_exc_code  (out_exc_code)
    );

    mem_checker #(
        .RAM_AWIDTH (10)
    ) u_checker (
        .clk           (clk),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_op         (in_op),
        .in_aluout     (in_aluout),
        .in_writedata  (in_writedata),
        .in_writereg   (in_writereg),
        .in_pc         (in_pc),
        .in_delay_slot (in_delay_slot),
        .in_exc_ri     (in_exc_ri),
        .in_exc_of     (in_exc_of),
        .ext_int       (ext_int),
        .out_valid     (out_valid),
        .out_op        (out_op),
        .out_result    (out_result),
        .out_writereg  (out_writereg),
        .out_exc_valid (out_exc_valid),
        .out_exc_code  (out_exc_code),
        .value_errs    (value_errs),
        .order_errs    (order_errs),
        .accepted      (accepted),
        .retired       (retired)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    // nonzero about one cycle in twenty
    function automatic logic [5:0] random_ext_int();
        if ($urandom_range(0, 99) < 5) return 6'($urandom_range(1, 63));
        return 6'h00;
    endfunction

    function automatic creg_addr_t random_cp0_reg();
        case ($urandom_range(0, 4))
            0:       return CP0_BADVADDR;
            1:       return CP0_STATUS;
            2:       return CP0_CAUSE;
            3:       return CP0_EPC;
            default: return 5'($urandom_range(0, 31));
        endcase
    endfunction

    task automatic randomize_item();
        int         r;
        logic [1:0] lo;
        creg_addr_t creg;
        r    = $urandom_range(0, 99);
        // half the accesses aligned, the rest random low bits
        lo   = ($urandom_range(0, 1) == 0) ? 2'b00 : 2'($urandom_range(0, 3));
        creg = random_cp0_reg();
        in_writedata  = $urandom();
        in_writereg   = 5'($urandom_range(0, 31));
        in_pc         = {30'($urandom()), 2'b00};
        in_delay_slot = ($urandom_range(0, 4) == 0);
        in_exc_ri     = ($urandom_range(0, 24) == 0);
        in_exc_of     = ($urandom_range(0, 24) == 0);
        in_aluout     = {24'h0, 6'($urandom_range(0, 63)), lo};
        if (r < 10) in_op = LB;
        else if (r < 18) in_op = LBU;
        else if (r < 28) in_op = LH;
        else if (r < 36) in_op = LHU;
        else if (r < 48) in_op = LW;
        else if (r < 56) in_op = SB;
        else if (r < 64) in_op = SH;
        else if (r < 76) in_op = SW;
        else if (r < 82) in_op = MFC0;
        else if (r < 89) in_op = MTC0;
        else if (r < 91) in_op = SYSCALL;
        else if (r < 93) in_op = BREAK;
        else if (r < 97) in_op = ERET;
        else in_op = ALU;
        if (in_op == MFC0 || in_op == MTC0) begin
            in_aluout = {27'($urandom()), creg};
            // often open the interrupt gate with a Status write
            if (creg == CP0_STATUS && $urandom_range(0, 1) == 1) begin
                in_writedata[1:0] = 2'b01;
            end
        end else if (in_op == ALU) begin
            in_aluout = $urandom();
        end
    endtask

    // present one item and hold it until the DUT takes it
    task automatic send_item();
        randomize_item();
        in_valid = 1'b1;
        ext_int  = random_ext_int();
        while (!in_ready) begin
            @(negedge clk);
            ext_int = random_ext_int();
        end
        @(negedge clk);
    endtask

    initial begin
        void'($urandom(49));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_op         = ALU;
        in_aluout     = '0;
        in_writedata  = '0;
        in_writereg   = '0;
        in_pc         = '0;
        in_delay_slot = 1'b0;
        in_exc_ri     = 1'b0;
        in_exc_of     = 1'b0;
        ext_int       = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < N_ITEMS; i++) begin
            if ($urandom_range(0, 15) == 0) begin
                in_valid = 1'b0;
                ext_int  = random_ext_int();
                @(negedge clk);
            end
            send_item();
        end
        in_valid = 1'b0;
        ext_int  = '0;
        while (retired != accepted) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("errors: value %0d, order %0d; accepted %0d of %0d, retired %0d",
                 value_errs, order_errs, accepted, N_ITEMS, retired);
        if (value_errs == 0 && order_errs == 0 && accepted == N_ITEMS &&
            retired == accepted) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
